// File: Bender.yml
package:
  name: pfd_ext

sources:
  - files:
      - verilog/pfd_meas_pkg.sv
      - verilog/pfd_host_pkg.sv
      - verilog/edge_sync.sv
      - verilog/phase_counter.sv
      - verilog/pulse_stretcher.sv
      - verilog/pfd_ctrl.sv
      - verilog/pfd_ext_top.sv
  - target: test
    files:
      - tests/tb_pfd_checks.sv
      - tests/tb_pfd_ext.sv

// File: sources.f
verilog/pfd_meas_pkg.sv
verilog/pfd_host_pkg.sv
verilog/edge_sync.sv
verilog/phase_counter.sv
verilog/pulse_stretcher.sv
verilog/pfd_ctrl.sv
verilog/pfd_ext_top.sv
tests/tb_pfd_checks.sv
tests/tb_pfd_ext.sv

// File: tests/tb_pfd_checks.sv
module tb_pfd_checks
    import pfd_meas_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic req_i,
    input  logic ack_i,
    input  logic rd_sign_i,
    input  cnt_t rd_diff_i,
    input  cnt_t rd_half_i,
    input  logic rd_overrun_i,
    input  logic p_ext_sign_i,
    input  logic p_ext_diff_i,
    input  logic f_ext_half_i,
    input  logic exp_sign_i,
    input  cnt_t exp_diff_i,
    input  cnt_t exp_half_i,
    input  logic exp_ovr_i,
    input  logic win_done_i,
    input  logic reset_chk_i,
    input  logic replay_chk_i,
    output int   err_cnt_o
);

    int   errs = 0;
    int   half_len;
    int   diff_len;
    int   period;
    logic half_d;
    logic diff_d;
    logic armed;

    assign err_cnt_o = errs;

    task automatic log_mismatch(input string name, input int exp, input int act);
        $display("** Error: %s expected %0h got %0h at %0t", name, exp, act, $time);
        errs++;
    endtask

    task automatic log_violation(input string what);
        $display("handshake or replay failure at %0t: %s", $time, what);
        errs++;
    endtask

    // run lengths of the replay pulses restart on each rising edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            half_d   <= 1'b0;
            diff_d   <= 1'b0;
            half_len <= 0;
            diff_len <= 0;
            period   <= 0;
            armed    <= 1'b0;
        end else begin
            half_d   <= f_ext_half_i;
            diff_d   <= p_ext_diff_i;
            half_len <= f_ext_half_i ? (half_d ? half_len + 1 : 1) : half_len;
            diff_len <= p_ext_diff_i ? (diff_d ? diff_len + 1 : 1) : diff_len;
            period   <= (f_ext_half_i && !half_d) ? 1 : period + 1;
            // only runs that start inside the check window count
            armed    <= replay_chk_i & (armed | (f_ext_half_i & ~half_d));
        end
    end

    a_reset_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        reset_chk_i |-> {ack_i, rd_overrun_i, p_ext_sign_i, p_ext_diff_i, f_ext_half_i} == 5'b0)
        else log_mismatch("{ack_o,rd_overrun_o,p_ext_sign_o,p_ext_diff_o,f_ext_half_o}", 0,
            $sampled({ack_i, rd_overrun_i, p_ext_sign_i, p_ext_diff_i, f_ext_half_i}));

    a_rd_sign: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> rd_sign_i == exp_sign_i)
        else log_mismatch("rd_sign_o", $sampled(exp_sign_i), $sampled(rd_sign_i));
    a_rd_diff: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> rd_diff_i == exp_diff_i)
        else log_mismatch("rd_diff_o", $sampled(exp_diff_i), $sampled(rd_diff_i));
    a_rd_half: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> rd_half_i == exp_half_i)
        else log_mismatch("rd_half_o", $sampled(exp_half_i), $sampled(rd_half_i));
    a_rd_ovr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> rd_overrun_i == exp_ovr_i)
        else log_mismatch("rd_overrun_o", $sampled(exp_ovr_i), $sampled(rd_overrun_i));

    a_ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> req_i)
        else log_violation("ack rose without a pending req");
    a_ack_after_window: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> win_done_i)
        else log_violation("ack rose before the measurement window completed");
    a_rd_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ack_i && $past(ack_i)) |-> $stable({rd_sign_i, rd_diff_i, rd_half_i, rd_overrun_i}))
        else log_violation("read data changed while ack was high");
    a_ack_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(ack_i) |-> !$past(req_i))
        else log_violation("ack dropped while req was still high");
    a_ack_drop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!req_i && ack_i) |=> !ack_i)
        else log_violation("ack stayed high one cycle after req dropped");

    a_ext_sign: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        replay_chk_i |-> p_ext_sign_i == exp_sign_i)
        else log_mismatch("p_ext_sign_o", $sampled(exp_sign_i), $sampled(p_ext_sign_i));
    a_ext_half: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (replay_chk_i && armed && half_d && !f_ext_half_i)
            |-> half_len == (int'(exp_half_i) << STRETCH_SHIFT))
        else log_mismatch("f_ext_half_o high cycles",
            $sampled(int'(exp_half_i) << STRETCH_SHIFT), $sampled(half_len));
    a_ext_diff: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (replay_chk_i && armed && diff_d && !p_ext_diff_i)
            |-> diff_len == (int'(exp_diff_i) << STRETCH_SHIFT))
        else log_mismatch("p_ext_diff_o high cycles",
            $sampled(int'(exp_diff_i) << STRETCH_SHIFT), $sampled(diff_len));
    a_ext_period: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (replay_chk_i && armed && f_ext_half_i && !half_d)
            |-> period == (int'(exp_half_i) << (STRETCH_SHIFT + 1)))
        else log_mismatch("f_ext_half_o period",
            $sampled(int'(exp_half_i) << (STRETCH_SHIFT + 1)), $sampled(period));

endmodule

// File: tests/tb_pfd_ext.sv
module tb_pfd_ext
    import pfd_meas_pkg::*;
();

    localparam int MAX_HIGH  = 12;
    localparam int N_WINDOWS = 16;
    // longest replay frame in cycles
    localparam int MAX_FRAME = MAX_HIGH << (STRETCH_SHIFT + 1);
    localparam int TIMEOUT   = 2 * N_WINDOWS * MAX_FRAME;

    logic clk = 1'b0;
    logic rst_n;
    logic sig_a;
    logic sig_b;
    logic req;
    logic ack;
    logic rd_sign;
    cnt_t rd_diff;
    cnt_t rd_half;
    logic rd_overrun;
    logic p_ext_sign;
    logic p_ext_diff;
    logic f_ext_half;

    // expected result of the latest window
    logic exp_sign;
    cnt_t exp_diff;
    cnt_t exp_half;
    logic exp_ovr;
    logic win_done;
    logic reset_chk;
    logic replay_chk;
    int   err_cnt;
    int   cycles = 0;
    int   n_tests = 0;
    int   errs_before = 0;

    always #4 clk = ~clk;

    pfd_ext_top UUT (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .sig_a_i      (sig_a),
        .sig_b_i      (sig_b),
        .req_i        (req),
        .ack_o        (ack),
        .rd_sign_o    (rd_sign),
        .rd_diff_o    (rd_diff),
        .rd_half_o    (rd_half),
        .rd_overrun_o (rd_overrun),
        .p_ext_sign_o (p_ext_sign),
        .p_ext_diff_o (p_ext_diff),
        .f_ext_half_o (f_ext_half)
    );

    tb_pfd_checks u_checks (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .req_i        (req),
        .ack_i        (ack),
        .rd_sign_i    (rd_sign),
        .rd_diff_i    (rd_diff),
        .rd_half_i    (rd_half),
        .rd_overrun_i (rd_overrun),
        .p_ext_sign_i (p_ext_sign),
        .p_ext_diff_i (p_ext_diff),
        .f_ext_half_i (f_ext_half),
        .exp_sign_i   (exp_sign),
        .exp_diff_i   (exp_diff),
        .exp_half_i   (exp_half),
        .exp_ovr_i    (exp_ovr),
        .win_done_i   (win_done),
        .reset_chk_i  (reset_chk),
        .replay_chk_i (replay_chk),
        .err_cnt_o    (err_cnt)
    );

    // one window where the leading input rises first and both stay high for hi cycles
    task automatic run_window(input logic b_first);
        int hi;
        int off;
        int t;
        hi  = $urandom_range(MAX_HIGH, 4);
        off = $urandom_range(hi - 1, 1);
        exp_sign <= b_first;
        exp_diff <= cnt_t'(off);
        exp_half <= cnt_t'(hi);
        for (t = 0; t <= off + hi; t++) begin
            @(posedge clk);
            sig_a <= b_first ? (t >= off && t < off + hi) : (t < hi);
            sig_b <= b_first ? (t < hi) : (t >= off && t < off + hi);
        end
        win_done <= 1'b1;
        repeat (10) @(posedge clk);
    endtask

    task automatic wait_ack(input logic level);
        do
            @(posedge clk);
        while (ack !== level);
    endtask

    task automatic raise_req(input int delay);
        repeat (delay) @(posedge clk);
        req <= 1'b1;
    endtask

    task automatic finish_read();
        wait_ack(1'b1);
        req <= 1'b0;
        wait_ack(1'b0);
        win_done <= 1'b0;
    endtask

    task automatic host_read(input int delay);
        raise_req(delay);
        finish_read();
    endtask

    task automatic report_test(input string name);
        n_tests++;
        $display("test %s done, %0d failed checks", name, err_cnt - errs_before);
        errs_before = err_cnt;
    endtask

    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int frame;
        void'($urandom(25));
        rst_n      <= 1'b0;
        sig_a      <= 1'b0;
        sig_b      <= 1'b0;
        req        <= 1'b0;
        exp_sign   <= 1'b0;
        exp_diff   <= '0;
        exp_half   <= '0;
        exp_ovr    <= 1'b0;
        win_done   <= 1'b0;
        reset_chk  <= 1'b0;
        replay_chk <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n     <= 1'b1;
        reset_chk <= 1'b1;
        repeat (20) @(posedge clk);
        reset_chk <= 1'b0;
        report_test("reset state");

        repeat (4) begin
            run_window(1'b0);
            host_read($urandom_range(6, 0));
        end
        report_test("A leads B");

        repeat (4) begin
            run_window(1'b1);
            host_read($urandom_range(6, 0));
        end
        report_test("B leads A");

        // sign 1 differs from the reset level of the sign output
        run_window(1'b1);
        host_read(0);
        // let the stretcher finish the old frame and load the new result
        repeat (2 * MAX_FRAME) @(posedge clk);
        frame = int'(exp_half) << (STRETCH_SHIFT + 1);
        replay_chk <= 1'b1;
        repeat (3 * frame + 4) @(posedge clk);
        replay_chk <= 1'b0;
        report_test("pulse replay");

        // req raised before any unread result exists
        repeat (4) begin
            raise_req($urandom_range(4, 0));
            repeat ($urandom_range(8, 0)) @(posedge clk);
            run_window($urandom_range(1, 0) != 0);
            finish_read();
        end
        report_test("handshake");

        run_window($urandom_range(1, 0) != 0);
        run_window($urandom_range(1, 0) != 0);
        exp_ovr <= 1'b1;
        host_read($urandom_range(6, 0));
        exp_ovr <= 1'b0;
        run_window($urandom_range(1, 0) != 0);
        host_read($urandom_range(6, 0));
        report_test("overrun");

        repeat (4) @(posedge clk);
        $display("tests run: %0d, failed checks: %0d", n_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog/edge_sync.sv
module edge_sync
    import pfd_host_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic data_i,
    output logic rise_o,
    output logic fall_o
);

    logic [SYNC_STAGES-1:0] sync_q;
    logic                   data_d;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= '0;
            data_d <= 1'b0;
            rise_o <= 1'b0;
            fall_o <= 1'b0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], data_i};
            data_d <= sync_q[SYNC_STAGES-1];
            // compare the last two synchronized samples
            rise_o <= sync_q[SYNC_STAGES-1] & ~data_d;
            fall_o <= ~sync_q[SYNC_STAGES-1] & data_d;
        end
    end

    a_rise_fall_excl: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(rise_o && fall_o)
    );

endmodule

// File: verilog/pfd_ctrl.sv
module pfd_ctrl
    import pfd_meas_pkg::*;
    import pfd_host_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic meas_done_i,
    input  logic meas_sign_i,
    input  cnt_t meas_diff_i,
    input  cnt_t meas_half_i,
    input  logic req_i,
    output logic ack_o,
    output logic rd_sign_o,
    output cnt_t rd_diff_o,
    output cnt_t rd_half_o,
    output logic rd_overrun_o,
    output logic hold_sign_o,
    output cnt_t hold_diff_o,
    output cnt_t hold_half_o
);

    ctrl_state_t state;
    logic        unread;
    logic        overrun;
    logic        grant;

    assign grant = (state == CTRL_IDLE) && req_i && unread;

    // latest result and its read status
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hold_sign_o <= 1'b0;
            hold_diff_o <= '0;
            hold_half_o <= '0;
            unread      <= 1'b0;
            overrun     <= 1'b0;
        end else begin
            if (meas_done_i) begin
                hold_sign_o <= meas_sign_i;
                hold_diff_o <= meas_diff_i;
                hold_half_o <= meas_half_i;
            end
            unread  <= meas_done_i | (unread & ~grant);
            // a result granted in the same cycle is not lost
            overrun <= ~grant & (overrun | (meas_done_i & unread));
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state        <= CTRL_IDLE;
            ack_o        <= 1'b0;
            rd_overrun_o <= 1'b0;
        end else begin
            case (state)
                CTRL_IDLE: begin
                    if (grant) begin
                        ack_o        <= 1'b1;
                        rd_overrun_o <= overrun;
                        state        <= CTRL_ACK;
                    end
                end
                CTRL_ACK, CTRL_RELEASE: begin
                    if (!req_i) begin
                        ack_o <= 1'b0;
                        state <= CTRL_IDLE;
                    end else begin
                        state <= CTRL_RELEASE;
                    end
                end
                default: begin
                    ack_o <= 1'b0;
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

    // snapshot taken on grant
    always_ff @(posedge clk_i) begin
        if (grant) begin
            rd_sign_o <= hold_sign_o;
            rd_diff_o <= hold_diff_o;
            rd_half_o <= hold_half_o;
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> $past(req_i)
    );

    a_rd_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (ack_o && $past(ack_o)) |-> $stable({rd_sign_o, rd_diff_o, rd_half_o, rd_overrun_o})
    );

endmodule

// File: verilog/pfd_ext_top.sv
module pfd_ext_top
    import pfd_meas_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic sig_a_i,
    input  logic sig_b_i,
    input  logic req_i,
    output logic ack_o,
    output logic rd_sign_o,
    output cnt_t rd_diff_o,
    output cnt_t rd_half_o,
    output logic rd_overrun_o,
    output logic p_ext_sign_o,
    output logic p_ext_diff_o,
    output logic f_ext_half_o
);

    logic a_rise;
    logic a_fall;
    logic b_rise;
    logic b_fall;

    logic meas_done;
    logic meas_sign;
    cnt_t meas_diff;
    cnt_t meas_half;

    logic hold_sign;
    cnt_t hold_diff;
    cnt_t hold_half;

    // matched delay on both inputs keeps relative timing exact
    edge_sync u_sync_a (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .data_i  (sig_a_i),
        .rise_o  (a_rise),
        .fall_o  (a_fall)
    );

    edge_sync u_sync_b (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .data_i  (sig_b_i),
        .rise_o  (b_rise),
        .fall_o  (b_fall)
    );

    phase_counter u_phase_counter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .a_rise_i    (a_rise),
        .a_fall_i    (a_fall),
        .b_rise_i    (b_rise),
        .b_fall_i    (b_fall),
        .meas_done_o (meas_done),
        .meas_sign_o (meas_sign),
        .meas_diff_o (meas_diff),
        .meas_half_o (meas_half)
    );

    pfd_ctrl u_pfd_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .meas_done_i  (meas_done),
        .meas_sign_i  (meas_sign),
        .meas_diff_i  (meas_diff),
        .meas_half_i  (meas_half),
        .req_i        (req_i),
        .ack_o        (ack_o),
        .rd_sign_o    (rd_sign_o),
        .rd_diff_o    (rd_diff_o),
        .rd_half_o    (rd_half_o),
        .rd_overrun_o (rd_overrun_o),
        .hold_sign_o  (hold_sign),
        .hold_diff_o  (hold_diff),
        .hold_half_o  (hold_half)
    );

    pulse_stretcher u_pulse_stretcher (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .hold_sign_i  (hold_sign),
        .hold_diff_i  (hold_diff),
        .hold_half_i  (hold_half),
        .p_ext_sign_o (p_ext_sign_o),
        .p_ext_diff_o (p_ext_diff_o),
        .f_ext_half_o (f_ext_half_o)
    );

endmodule

// File: verilog/pfd_host_pkg.sv
package pfd_host_pkg;

    // synchronizer depth for the asynchronous inputs
    localparam int SYNC_STAGES = 2;

    // host read FSM
    typedef enum logic [1:0] {
        CTRL_IDLE,
        // result presented, ack high
        CTRL_ACK,
        // ack held until req drops
        CTRL_RELEASE
    } ctrl_state_t;

endpackage

// File: verilog/pfd_meas_pkg.sv
package pfd_meas_pkg;

    // width of the phase and half-period counts
    localparam int CNT_WIDTH = 16;

    // counts are scaled by this shift to set output pulse widths
    // and it stays small so one replay frame stays short
    localparam int STRETCH_SHIFT = 2;

    // one extra bit so a frame can span a full period
    localparam int FRAME_WIDTH = CNT_WIDTH + STRETCH_SHIFT + 1;

    // number of clock cycles
    typedef logic [CNT_WIDTH-1:0] cnt_t;

    // replay frame position
    typedef logic [FRAME_WIDTH-1:0] frame_t;

endpackage

// File: verilog/phase_counter.sv
module phase_counter
    import pfd_meas_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic a_rise_i,
    input  logic a_fall_i,
    input  logic b_rise_i,
    input  logic b_fall_i,
    output logic meas_done_o,
    output logic meas_sign_o,
    output cnt_t meas_diff_o,
    output cnt_t meas_half_o
);

    logic a_rose;
    logic a_fell;
    logic b_rose;
    logic b_fell;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            a_rose      <= 1'b0;
            a_fell      <= 1'b0;
            b_rose      <= 1'b0;
            b_fell      <= 1'b0;
            meas_done_o <= 1'b0;
            meas_sign_o <= 1'b0;
            meas_diff_o <= '0;
            meas_half_o <= '0;
        end else begin
            // a rise strobe opens the next window even in the done cycle
            a_rose <= a_rise_i | (a_rose & ~meas_done_o);
            b_rose <= b_rise_i | (b_rose & ~meas_done_o);

            // stray falls outside a window are ignored
            a_fell <= (a_fall_i & a_rose) | (a_fell & ~meas_done_o);
            b_fell <= (b_fall_i & b_rose) | (b_fell & ~meas_done_o);

            meas_done_o <= ~meas_done_o & a_fell & b_fell;

            if (meas_done_o) begin
                meas_sign_o <= 1'b0;
                meas_diff_o <= '0;
                meas_half_o <= '0;
            end else begin
                // B rose first
                if (b_rose && !a_rose) begin
                    meas_sign_o <= 1'b1;
                end
                // gap between the two rising edges
                if (a_rose ^ b_rose) begin
                    meas_diff_o <= meas_diff_o + 1'b1;
                end
                // high time of A
                if (a_rose && !a_fell) begin
                    meas_half_o <= meas_half_o + 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/pulse_stretcher.sv
module pulse_stretcher
    import pfd_meas_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic hold_sign_i,
    input  cnt_t hold_diff_i,
    input  cnt_t hold_half_i,
    output logic p_ext_sign_o,
    output logic p_ext_diff_o,
    output logic f_ext_half_o
);

    frame_t frame_q;
    frame_t frame_nxt;
    frame_t frame_len;
    frame_t pos_nxt;
    cnt_t   ld_diff;
    cnt_t   ld_half;
    cnt_t   diff_nxt;
    cnt_t   half_nxt;
    logic   frame_end;

    function automatic frame_t scale(cnt_t cnt);
        return {1'b0, cnt, {STRETCH_SHIFT{1'b0}}};
    endfunction

    // full period is twice the scaled high time
    assign frame_len = {ld_half, {STRETCH_SHIFT{1'b0}}, 1'b0};
    assign frame_nxt = frame_q + 1'b1;
    assign frame_end = frame_nxt >= frame_len;

    always_comb begin
        pos_nxt  = frame_end ? '0 : frame_nxt;
        diff_nxt = frame_end ? hold_diff_i : ld_diff;
        half_nxt = frame_end ? hold_half_i : ld_half;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            frame_q      <= '0;
            ld_diff      <= '0;
            ld_half      <= '0;
            p_ext_sign_o <= 1'b0;
            p_ext_diff_o <= 1'b0;
            f_ext_half_o <= 1'b0;
        end else begin
            frame_q <= pos_nxt;
            ld_diff <= diff_nxt;
            ld_half <= half_nxt;
            if (frame_end) begin
                p_ext_sign_o <= hold_sign_i;
            end
            // outputs follow the position they are registered with
            p_ext_diff_o <= pos_nxt < scale(diff_nxt);
            f_ext_half_o <= pos_nxt < scale(half_nxt);
        end
    end

endmodule
